/* design/memPkg.sv */
package memPkg;

	// Address bits actually decoded, addresses wrap past this
	localparam int ADDR_BITS = 9;

	// Storage depth in bytes
	localparam int MEM_BYTES = 512;

	// Unsigned loads
	localparam logic [5:0] OP_LDW  = 6'b000000;
	localparam logic [5:0] OP_LDUB = 6'b000001;
	localparam logic [5:0] OP_LDUH = 6'b000010;

	// Stores
	// Doubleword variants are split into two words by the control unit
	localparam logic [5:0] OP_STW  = 6'b000100;
	localparam logic [5:0] OP_STB  = 6'b000101;
	localparam logic [5:0] OP_STH  = 6'b000110;

	// Signed loads
	localparam logic [5:0] OP_LDSB = 6'b001001;
	localparam logic [5:0] OP_LDSH = 6'b001010;

	// Access width
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} memSize_t;

endpackage

/* design/accessDecoder.sv */
`timescale 1ns/1ps

module accessDecoder (
	input  logic             clk,
	input  logic             reset,
	input  logic             enable,
	input  logic [5:0]       opCode,
	input  logic [31:0]      marAddress,
	output logic             storeEnable,
	output memPkg::memSize_t storeSize,
	output logic             loadValid,
	output logic             storeDone,
	output logic             storeError,
	output logic             loadSigned,
	output memPkg::memSize_t loadSize
);

	// Opcode classification
	logic             isLoad;
	logic             isStore;
	logic             isSigned;
	memPkg::memSize_t accessSize;

	// Alignment check result for stores
	logic             aligned;

	always_comb begin
		isLoad     = 1'b0;
		isStore    = 1'b0;
		isSigned   = 1'b0;
		accessSize = memPkg::SIZE_WORD;
		case (opCode)
			memPkg::OP_LDW: begin
				isLoad     = 1'b1;
			end
			memPkg::OP_LDUB: begin
				isLoad     = 1'b1;
				accessSize = memPkg::SIZE_BYTE;
			end
			memPkg::OP_LDUH: begin
				isLoad     = 1'b1;
				accessSize = memPkg::SIZE_HALF;
			end
			memPkg::OP_LDSB: begin
				isLoad     = 1'b1;
				isSigned   = 1'b1;
				accessSize = memPkg::SIZE_BYTE;
			end
			memPkg::OP_LDSH: begin
				isLoad     = 1'b1;
				isSigned   = 1'b1;
				accessSize = memPkg::SIZE_HALF;
			end
			memPkg::OP_STW: begin
				isStore    = 1'b1;
			end
			memPkg::OP_STH: begin
				isStore    = 1'b1;
				accessSize = memPkg::SIZE_HALF;
			end
			memPkg::OP_STB: begin
				isStore    = 1'b1;
				accessSize = memPkg::SIZE_BYTE;
			end
			// Unknown opcodes fall through as neither load nor store
			default: begin
				isLoad     = 1'b0;
			end
		endcase
	end

	// Words need a multiple of four, halfwords an even address
	always_comb begin
		case (accessSize)
			memPkg::SIZE_WORD: aligned = (marAddress[1:0] == 2'b00);
			memPkg::SIZE_HALF: aligned = ~marAddress[0];
			default:           aligned = 1'b1;
		endcase
	end

	// Same-cycle write request to the byte array
	assign storeEnable = enable & isStore & aligned;
	assign storeSize   = accessSize;

	// Request status, lined up with the array's registered read
	always_ff @(posedge clk) begin
		if (reset) begin
			loadValid  <= 1'b0;
			storeDone  <= 1'b0;
			storeError <= 1'b0;
		end else begin
			loadValid  <= enable & isLoad;
			storeDone  <= enable & isStore & aligned;
			storeError <= enable & isStore & ~aligned;
		end
	end

	// Load format only matters when loadValid is set
	always_ff @(posedge clk) begin
		if (enable && isLoad) begin
			loadSize   <= accessSize;
			loadSigned <= isSigned;
		end
	end

endmodule

/* design/byteRam.sv */
`timescale 1ns/1ps

module byteRam (
	input  logic             clk,
	input  logic             storeEnable,
	input  memPkg::memSize_t storeSize,
	input  logic [31:0]      marAddress,
	input  logic [31:0]      mdrDataIn,
	output logic [31:0]      readBytes
);

	// Byte-wide storage, no reset
	logic [7:0] mem [memPkg::MEM_BYTES];

	// Four consecutive byte addresses starting at the request, wrapping at the top
	logic [memPkg::ADDR_BITS-1:0] laneAddr [4];

	// Per-lane write enable and data
	logic [3:0] laneWrite;
	logic [7:0] laneData [4];

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			laneAddr[i] = marAddress[memPkg::ADDR_BITS-1:0] + memPkg::ADDR_BITS'(i);
		end
	end

	// Big-endian lanes, data taken from the low end of mdrDataIn
	always_comb begin
		laneData[0] = mdrDataIn[31:24];
		laneData[1] = mdrDataIn[23:16];
		laneData[2] = mdrDataIn[15:8];
		laneData[3] = mdrDataIn[7:0];
		case (storeSize)
			memPkg::SIZE_WORD: begin
				laneWrite = 4'b1111;
			end
			memPkg::SIZE_HALF: begin
				// Upper half goes to the lower address
				laneWrite   = 4'b0011;
				laneData[0] = mdrDataIn[15:8];
				laneData[1] = mdrDataIn[7:0];
			end
			default: begin
				laneWrite   = 4'b0001;
				laneData[0] = mdrDataIn[7:0];
			end
		endcase
	end

	// Write and read share the edge
	// Read picks up contents from before this edge's write
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (storeEnable && laneWrite[i]) begin
				mem[laneAddr[i]] <= laneData[i];
			end
		end
		readBytes <= {mem[laneAddr[0]], mem[laneAddr[1]], mem[laneAddr[2]], mem[laneAddr[3]]};
	end

endmodule

/* design/memResponse.sv */
`timescale 1ns/1ps

module memResponse (
	input  logic             clk,
	input  logic             reset,
	input  logic             loadValid,
	input  logic             storeDone,
	input  logic             storeError,
	input  logic             loadSigned,
	input  memPkg::memSize_t loadSize,
	input  logic [31:0]      readBytes,
	output logic [31:0]      mdrDataOut,
	output logic             mfc,
	output logic             mset
);

	// Extension bit for the upper part of the result
	logic        fillBit;

	// Load result before registering
	logic [31:0] loadData;

	// First loaded byte always sits in the top lane
	assign fillBit = loadSigned & readBytes[31];

	always_comb begin
		case (loadSize)
			memPkg::SIZE_WORD: begin
				loadData = readBytes;
			end
			memPkg::SIZE_HALF: begin
				// Two bytes, right-justified
				loadData = {{16{fillBit}}, readBytes[31:16]};
			end
			default: begin
				// Single byte, right-justified
				loadData = {{24{fillBit}}, readBytes[31:24]};
			end
		endcase
	end

	// Completion and error strobes, one cycle each
	always_ff @(posedge clk) begin
		if (reset) begin
			mfc  <= 1'b0;
			mset <= 1'b0;
		end else begin
			mfc  <= loadValid | storeDone;
			mset <= storeError;
		end
	end

	// Data register holds until the next load
	// Stores leave it alone
	always_ff @(posedge clk) begin
		if (reset) begin
			mdrDataOut <= 32'h0;
		end else if (loadValid) begin
			mdrDataOut <= loadData;
		end
	end

endmodule

/* design/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory (
	input  logic        clk,
	input  logic        reset,
	input  logic        enable,
	input  logic [5:0]  opCode,
	input  logic [31:0] marAddress,
	input  logic [31:0] mdrDataIn,
	output logic [31:0] mdrDataOut,
	output logic        mfc,
	output logic        mset
);

	// Decoder to array, request cycle
	logic             storeEnable;
	memPkg::memSize_t storeSize;

	// Decoder to response stage, one cycle later
	logic             loadValid;
	logic             storeDone;
	logic             storeError;
	logic             loadSigned;
	memPkg::memSize_t loadSize;

	// Array read data to response stage
	logic [31:0]      readBytes;

	accessDecoder decoder (
		.clk        (clk),
		.reset      (reset),
		.enable     (enable),
		.opCode     (opCode),
		.marAddress (marAddress),
		.storeEnable(storeEnable),
		.storeSize  (storeSize),
		.loadValid  (loadValid),
		.storeDone  (storeDone),
		.storeError (storeError),
		.loadSigned (loadSigned),
		.loadSize   (loadSize)
	);

	// Runs beside the decoder in the request cycle
	byteRam ram (
		.clk        (clk),
		.storeEnable(storeEnable),
		.storeSize  (storeSize),
		.marAddress (marAddress),
		.mdrDataIn  (mdrDataIn),
		.readBytes  (readBytes)
	);

	memResponse response (
		.clk        (clk),
		.reset      (reset),
		.loadValid  (loadValid),
		.storeDone  (storeDone),
		.storeError (storeError),
		.loadSigned (loadSigned),
		.loadSize   (loadSize),
		.readBytes  (readBytes),
		.mdrDataOut (mdrDataOut),
		.mfc        (mfc),
		.mset       (mset)
	);

endmodule

/* test/memRefModel.svh */
`ifndef MEM_REF_MODEL_SVH
`define MEM_REF_MODEL_SVH

// Expected byte image of the memory
logic [7:0] refMem [memPkg::MEM_BYTES];

// Byte address with wrap at the top of the array
function automatic logic [memPkg::ADDR_BITS-1:0] wrapAddr(input logic [31:0] addr,
	input int offset);
	return memPkg::ADDR_BITS'(addr + 32'(offset));
endfunction

function automatic bit isLoadOp(input logic [5:0] op);
	return op == memPkg::OP_LDW || op == memPkg::OP_LDUB || op == memPkg::OP_LDUH ||
		op == memPkg::OP_LDSB || op == memPkg::OP_LDSH;
endfunction

function automatic bit isStoreOp(input logic [5:0] op);
	return op == memPkg::OP_STW || op == memPkg::OP_STH || op == memPkg::OP_STB;
endfunction

// Access width in bytes, zero for unknown opcodes
function automatic int accessBytes(input logic [5:0] op);
	case (op)
		memPkg::OP_LDW, memPkg::OP_STW: return 4;
		memPkg::OP_LDUH, memPkg::OP_LDSH, memPkg::OP_STH: return 2;
		memPkg::OP_LDUB, memPkg::OP_LDSB, memPkg::OP_STB: return 1;
		default: return 0;
	endcase
endfunction

// Word stores on multiples of four, halfword stores on even addresses
function automatic bit storeAligned(input logic [5:0] op, input logic [31:0] addr);
	case (op)
		memPkg::OP_STW: return addr[1:0] == 2'b00;
		memPkg::OP_STH: return addr[0] == 1'b0;
		default: return 1'b1;
	endcase
endfunction

// Big-endian, low end of the data goes out
task automatic refStore(input logic [5:0] op, input logic [31:0] addr, input logic [31:0] data);
	int n;
	n = accessBytes(op);
	for (int i = 0; i < n; i++) begin
		refMem[wrapAddr(addr, i)] = data[8*(n-1-i) +: 8];
	end
endtask

// First byte ends up most significant, upper bits zero or sign copies
function automatic logic [31:0] refLoad(input logic [5:0] op, input logic [31:0] addr);
	logic [31:0] value;
	int          n;
	n = accessBytes(op);
	value = 32'h0;
	for (int i = 0; i < n; i++) begin
		value = {value[23:0], refMem[wrapAddr(addr, i)]};
	end
	if ((op == memPkg::OP_LDSB || op == memPkg::OP_LDSH) && value[8*n-1]) begin
		for (int b = 8*n; b < 32; b++) begin
			value[b] = 1'b1;
		end
	end
	return value;
endfunction

`endif

/* test/dataMemoryTb.sv */
`timescale 1ns/1ps

module dataMemoryTb;

	logic        clk;
	logic        reset;
	logic        enable;
	logic [5:0]  opCode;
	logic [31:0] marAddress;
	logic [31:0] mdrDataIn;
	logic [31:0] mdrDataOut;
	logic        mfc;
	logic        mset;

	integer      seed;

	// Last predicted load result, what mdrDataOut should hold
	logic [31:0] lastLoad;

	// Expected responses with the oldest request first
	bit          expMfcQ [$];
	bit          expMsetQ [$];
	logic [31:0] expDataQ [$];

	`include "memRefModel.svh"

	dataMemory dut (
		.clk       (clk),
		.reset     (reset),
		.enable    (enable),
		.opCode    (opCode),
		.marAddress(marAddress),
		.mdrDataIn (mdrDataIn),
		.mdrDataOut(mdrDataOut),
		.mfc       (mfc),
		.mset      (mset)
	);

	always #2 clk = ~clk;

	task automatic stopOnFailure();
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	// Fill pattern hashed from the whole byte address
	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return (addr + 32'd1) * 32'h9e37_79b9;
	endfunction

	// Random opcode pool with two unknown codes at the end
	function automatic logic [5:0] pickOp(input int idx);
		case (idx)
			0: return memPkg::OP_LDW;
			1: return memPkg::OP_LDUB;
			2: return memPkg::OP_LDUH;
			3: return memPkg::OP_LDSB;
			4: return memPkg::OP_LDSH;
			5: return memPkg::OP_STW;
			6: return memPkg::OP_STH;
			7: return memPkg::OP_STB;
			8: return 6'b000011;
			default: return 6'b111111;
		endcase
	endfunction

	// Oldest request's response is registered one edge after its sampling edge
	// and is what the second edge sees
	task automatic checkResponse();
		bit          eMfc;
		bit          eMset;
		logic [31:0] eData;
		eMfc = expMfcQ.pop_front();
		eMset = expMsetQ.pop_front();
		eData = expDataQ.pop_front();
		assert (mfc === eMfc) else begin
			$display("Error at %0t ns: mfc expected %0b, actual %0b", $time, eMfc, mfc);
			stopOnFailure();
		end
		assert (mset === eMset) else begin
			$display("Error at %0t ns: mset expected %0b, actual %0b", $time, eMset, mset);
			stopOnFailure();
		end
		assert (mdrDataOut === eData) else begin
			$display("Error at %0t ns: mdrDataOut expected %h, actual %h",
				$time, eData, mdrDataOut);
			stopOnFailure();
		end
	endtask

	// Drives one request or idle cycle per clock
	task automatic issue(input logic en, input logic [5:0] op, input logic [31:0] addr,
		input logic [31:0] data);
		bit doLoad;
		bit doStore;
		bit aligned;
		doLoad = en && isLoadOp(op);
		doStore = en && isStoreOp(op);
		aligned = storeAligned(op, addr);
		enable = en;
		opCode = op;
		marAddress = addr;
		mdrDataIn = data;
		expMfcQ.push_back(doLoad || (doStore && aligned));
		expMsetQ.push_back(doStore && !aligned);
		// Prediction before the update keeps request order
		if (doLoad) begin
			lastLoad = refLoad(op, addr);
		end
		// Stores and idle cycles leave the data register as it was
		expDataQ.push_back(lastLoad);
		if (doStore && aligned) begin
			refStore(op, addr, data);
		end
		@(posedge clk);
		#1;
		if (expMfcQ.size() == 2) begin
			checkResponse();
		end
	endtask

	task automatic idle(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			issue(1'b0, 6'b111111, 32'h0, 32'h0);
		end
	endtask

	// Hang guard
	initial begin
		#20000;
		$display("Simulation ran past its time limit");
		stopOnFailure();
	end

	initial begin
		logic [31:0] rnd;
		logic [31:0] addr;
		int          opIdx;
		seed = 32'hb1e9_37b5;
		lastLoad = 32'h0;
		clk = 1'b0;
		reset = 1'b1;
		enable = 1'b0;
		opCode = 6'h0;
		marAddress = 32'h0;
		mdrDataIn = 32'h0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		assert (mfc === 1'b0) else begin
			$display("Error at %0t ns: mfc expected 0, actual %0b", $time, mfc);
			stopOnFailure();
		end
		assert (mset === 1'b0) else begin
			$display("Error at %0t ns: mset expected 0, actual %0b", $time, mset);
			stopOnFailure();
		end
		assert (mdrDataOut === 32'h0) else begin
			$display("Error at %0t ns: mdrDataOut expected %h, actual %h",
				$time, 32'h0, mdrDataOut);
			stopOnFailure();
		end
		// Preload every byte so that no load sees unknown contents
		for (int a = 0; a < memPkg::MEM_BYTES; a += 4) begin
			issue(1'b1, memPkg::OP_STW, 32'(a), fillWord(32'(a)));
		end
		// Word round trip then single bytes in big-endian order
		issue(1'b1, memPkg::OP_STW, 32'h40, 32'hcafe_f00d);
		issue(1'b1, memPkg::OP_LDW, 32'h40, 32'h0);
		for (int i = 0; i < 4; i++) begin
			issue(1'b1, memPkg::OP_LDUB, 32'h40 + 32'(i), 32'h0);
		end
		// Bytes 7f 80 80 01 give both sign bit values
		issue(1'b1, memPkg::OP_STW, 32'h80, 32'h7f80_8001);
		issue(1'b1, memPkg::OP_LDSB, 32'h80, 32'h0);
		issue(1'b1, memPkg::OP_LDSB, 32'h81, 32'h0);
		issue(1'b1, memPkg::OP_LDUB, 32'h81, 32'h0);
		issue(1'b1, memPkg::OP_LDSH, 32'h80, 32'h0);
		issue(1'b1, memPkg::OP_LDSH, 32'h81, 32'h0);
		issue(1'b1, memPkg::OP_LDUH, 32'h82, 32'h0);
		issue(1'b1, memPkg::OP_LDUH, 32'h80, 32'h0);
		// Misaligned stores leave the word untouched
		issue(1'b1, memPkg::OP_STH, 32'h91, 32'hdead_beef);
		issue(1'b1, memPkg::OP_STW, 32'h92, 32'hdead_beef);
		issue(1'b1, memPkg::OP_STW, 32'h93, 32'hdead_beef);
		issue(1'b1, memPkg::OP_LDW, 32'h90, 32'h0);
		// Partial stores next to preloaded neighbors
		issue(1'b1, memPkg::OP_STB, 32'ha1, 32'hffff_ff5a);
		issue(1'b1, memPkg::OP_STH, 32'ha6, 32'h1234_beef);
		issue(1'b1, memPkg::OP_LDW, 32'ha0, 32'h0);
		issue(1'b1, memPkg::OP_LDW, 32'ha4, 32'h0);
		// Back-to-back store and load of the same address
		issue(1'b1, memPkg::OP_STW, 32'h1f0, 32'h0bad_cafe);
		issue(1'b1, memPkg::OP_LDW, 32'h1f0, 32'h0);
		issue(1'b1, memPkg::OP_STB, 32'h1f3, 32'h0000_00a5);
		issue(1'b1, memPkg::OP_LDSB, 32'h1f3, 32'h0);
		// Loads across the top of the array
		issue(1'b1, memPkg::OP_LDW, 32'h1ff, 32'h0);
		issue(1'b1, memPkg::OP_LDSH, 32'h1ff, 32'h0);
		issue(1'b1, memPkg::OP_LDUH, 32'hffff_fdff, 32'h0);
		// Unknown opcodes give no pulse
		issue(1'b1, 6'b000011, 32'h40, 32'h0);
		issue(1'b1, 6'b111111, 32'h44, 32'h0);
		// Random stream with half of it around the wrap point
		for (int n = 0; n < 300; n++) begin
			rnd = $random(seed);
			opIdx = rnd[19:16] % 4'd10;
			if (rnd[0]) begin
				addr = {rnd[31:9], 9'h1f8 + {5'b0, rnd[7:4]}};
			end else begin
				addr = $random(seed);
			end
			issue(rnd[10:8] != 3'b000, pickOp(opIdx), addr, $random(seed));
		end
		// Let the last requests come out
		idle(2);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* filelist.f */
+incdir+test
design/memPkg.sv
design/accessDecoder.sv
design/byteRam.sv
design/memResponse.sv
design/dataMemory.sv
test/dataMemoryTb.sv

/* Makefile */
# Verilator build and run of the data memory testbench

VERILATOR ?= verilator
TOP       ?= dataMemoryTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

.PHONY: sim clean

# A failing run ends in $$fatal, so the binary's exit status fails the target
sim:
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
